// File: hdl/rs_block_parity.sv
`timescale 1ns/1ps
`default_nettype none

module rs_block_parity
    import udp_rs_encode_pkg::*;
(
    input  logic [8*rs_t-1:0] block,
    output logic [8*rs_t-1:0] parity
);

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] prod;
        logic [7:0] shifted;
        prod = 8'h00;
        shifted = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                prod = prod ^ shifted;
            end
            shifted = {shifted[6:0], 1'b0} ^ (shifted[7] ? rs_gf_poly : 8'h00);
        end
        return prod;
    endfunction

    // g(x) = (x + a^0)(x + a^1)...(x + a^15), monic term dropped
    function automatic logic [8*rs_t-1:0] gen_poly();
        logic [7:0]        g [rs_t+1];
        logic [7:0]        root;
        logic [8*rs_t-1:0] coef;
        for (int j = 0; j <= rs_t; j++) begin
            g[j] = 8'h00;
        end
        g[0] = 8'h01;
        root = 8'h01;
        for (int i = 0; i < rs_t; i++) begin
            for (int j = rs_t; j > 0; j--) begin
                g[j] = g[j-1] ^ gf_mul(g[j], root);
            end
            g[0] = gf_mul(g[0], root);
            root = gf_mul(root, 8'h02);
        end
        for (int j = 0; j < rs_t; j++) begin
            coef[8*j +: 8] = g[j];
        end
        return coef;
    endfunction

    localparam logic [8*rs_t-1:0] gen_coef = gen_poly();

    always_comb begin
        logic [7:0] rem [rs_t];
        logic [7:0] fb;
        for (int j = 0; j < rs_t; j++) begin
            rem[j] = 8'h00;
        end
        // byte 0 of the block enters the divider first
        for (int k = 0; k < rs_t; k++) begin
            fb = block[8*k +: 8] ^ rem[rs_t-1];
            for (int j = rs_t - 1; j > 0; j--) begin
                rem[j] = rem[j-1] ^ gf_mul(fb, gen_coef[8*j +: 8]);
            end
            rem[0] = gf_mul(fb, gen_coef[7:0]);
        end
        for (int k = 0; k < rs_t; k++) begin
            parity[8*k +: 8] = rem[rs_t-1-k];
        end
    end

endmodule

`default_nettype wire

// File: hdl/udp_rs_encode_in.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_in
    import udp_rs_noc_pkg::*;
    import udp_rs_encode_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           noc_in_val,
    input  logic [noc_data_width-1:0]      noc_in_data,
    output logic                           noc_in_rdy,
    output logic                           enc_in_val,
    output logic [noc_data_width-1:0]      enc_in_data,
    input  logic                           enc_in_rdy,
    output logic                           meta_val,
    input  logic                           meta_rdy,
    output logic [ip_addr_w-1:0]           src_ip,
    output logic [ip_addr_w-1:0]           dst_ip,
    output logic [port_num_w-1:0]          src_port,
    output logic [port_num_w-1:0]          dst_port,
    output logic [udp_length_w-1:0]        data_len,
    output logic [client_num_blocks_w-1:0] num_blocks
);

    typedef enum logic [1:0] {st_hdr, st_meta, st_client, st_blocks} in_state_e;

    in_state_e                      state;
    in_state_e                      state_next;
    logic [client_num_blocks_w-1:0] blocks_left;
    logic [client_num_blocks_w-1:0] client_blocks;
    udp_metadata_flit               in_meta;
    logic                           meta_acc;
    logic                           client_acc;
    logic                           block_acc;

    assign in_meta = noc_in_data;
    assign client_blocks = noc_in_data[client_num_blocks_w-1:0];
    assign enc_in_data = noc_in_data;

    assign meta_acc = (state == st_meta) && noc_in_val;
    assign client_acc = (state == st_client) && noc_in_val;
    assign block_acc = enc_in_val && enc_in_rdy;

    always_comb begin
        state_next = state;
        noc_in_rdy = 1'b0;
        enc_in_val = 1'b0;
        case (state)
            st_hdr: begin
                // hold off the next request until the last one is handed over
                noc_in_rdy = ~meta_val;
                if (noc_in_val && !meta_val) begin
                    state_next = st_meta;
                end
            end
            st_meta: begin
                noc_in_rdy = 1'b1;
                if (noc_in_val) begin
                    state_next = st_client;
                end
            end
            st_client: begin
                noc_in_rdy = 1'b1;
                if (noc_in_val) begin
                    state_next = (client_blocks == '0) ? st_hdr : st_blocks;
                end
            end
            st_blocks: begin
                noc_in_rdy = enc_in_rdy;
                enc_in_val = noc_in_val;
                if (block_acc && blocks_left == client_num_blocks_w'(1)) begin
                    state_next = st_hdr;
                end
            end
            default: state_next = st_hdr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_hdr;
            meta_val <= 1'b0;
            blocks_left <= '0;
        end else begin
            state <= state_next;
            if (meta_val && meta_rdy) begin
                meta_val <= 1'b0;
            end
            if (client_acc) begin
                meta_val <= 1'b1;
                blocks_left <= client_blocks;
            end else if (block_acc) begin
                blocks_left <= blocks_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (meta_acc) begin
            src_ip <= in_meta.src_ip;
            dst_ip <= in_meta.dst_ip;
            src_port <= in_meta.src_port;
            dst_port <= in_meta.dst_port;
            data_len <= in_meta.data_length;
        end
        if (client_acc) begin
            num_blocks <= client_blocks;
        end
    end

endmodule

`default_nettype wire

// File: hdl/udp_rs_encode_out_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_out_ctrl
    import udp_rs_encode_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            meta_val,
    input  logic            enc_out_val,
    input  logic            noc_out_rdy,
    input  logic            last_data_flit,
    output logic            store_meta,
    output udp_rs_tx_flit_e out_sel,
    output logic            incr_data_flit,
    output logic            noc_out_val,
    output logic            enc_out_rdy
);

    typedef enum logic [1:0] {st_idle, st_hdr, st_meta, st_data} out_state_e;

    out_state_e state;
    out_state_e state_next;

    always_comb begin
        state_next = state;
        store_meta = 1'b0;
        out_sel = data;
        incr_data_flit = 1'b0;
        noc_out_val = 1'b0;
        enc_out_rdy = 1'b0;
        case (state)
            st_idle: begin
                store_meta = meta_val;
                if (meta_val) begin
                    state_next = st_hdr;
                end
            end
            st_hdr: begin
                out_sel = hdr;
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = st_meta;
                end
            end
            st_meta: begin
                out_sel = meta;
                noc_out_val = 1'b1;
                if (noc_out_rdy) begin
                    state_next = st_data;
                end
            end
            st_data: begin
                // encoder output passes straight to the NoC
                noc_out_val = enc_out_val;
                enc_out_rdy = noc_out_rdy;
                incr_data_flit = enc_out_val & noc_out_rdy;
                if (enc_out_val && noc_out_rdy && last_data_flit) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/udp_rs_encode_out_datap.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_out_datap
    import udp_rs_noc_pkg::*;
    import udp_rs_encode_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [ip_addr_w-1:0]           src_ip,
    input  logic [ip_addr_w-1:0]           dst_ip,
    input  logic [port_num_w-1:0]          src_port,
    input  logic [port_num_w-1:0]          dst_port,
    input  logic [udp_length_w-1:0]        data_len,
    input  logic [client_num_blocks_w-1:0] num_blocks,
    input  logic [noc_data_width-1:0]      enc_out_data,
    input  logic                           store_meta,
    input  udp_rs_tx_flit_e                out_sel,
    input  logic                           incr_data_flit,
    output logic [noc_data_width-1:0]      noc_out_data,
    output logic                           last_data_flit
);

    logic [ip_addr_w-1:0]           src_ip_r;
    logic [ip_addr_w-1:0]           dst_ip_r;
    logic [port_num_w-1:0]          src_port_r;
    logic [port_num_w-1:0]          dst_port_r;
    logic [udp_length_w-1:0]        data_len_r;
    logic [client_num_blocks_w-1:0] num_blocks_r;
    logic [msg_length_width-1:0]    flit_cnt;
    logic [udp_length_w-1:0]        parity_len;
    logic [udp_length_w-1:0]        resp_len;
    logic [msg_length_width-1:0]    num_data_flits;
    noc_hdr_flit                    hdr_flit;
    udp_metadata_flit               meta_flit;

    assign parity_len = udp_length_w'(num_blocks_r) << $clog2(rs_t);

    // the client request flit is not part of the response
    assign resp_len = data_len_r + parity_len - udp_length_w'(noc_data_bytes);

    assign num_data_flits = msg_length_width'(
        (resp_len + udp_length_w'(noc_data_bytes - 1)) >> noc_data_bytes_w);

    assign last_data_flit = flit_cnt == (num_data_flits - 1'b1);

    always_ff @(posedge clk) begin
        if (store_meta) begin
            src_ip_r <= src_ip;
            dst_ip_r <= dst_ip;
            src_port_r <= src_port;
            dst_port_r <= dst_port;
            data_len_r <= data_len;
            num_blocks_r <= num_blocks;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || store_meta) begin
            flit_cnt <= '0;
        end else if (incr_data_flit) begin
            flit_cnt <= flit_cnt + 1'b1;
        end
    end

    always_comb begin
        hdr_flit = '0;
        hdr_flit.dst_x = udp_tx_tile_x;
        hdr_flit.dst_y = udp_tx_tile_y;
        hdr_flit.src_x = encode_tile_x;
        hdr_flit.src_y = encode_tile_y;
        // one metadata flit, then the data and parity flits
        hdr_flit.msg_len = num_data_flits + msg_length_width'(1);
        hdr_flit.msg_type = udp_tx_segment;
        hdr_flit.metadata_flits = 8'd1;
    end

    always_comb begin
        meta_flit = '0;
        meta_flit.src_ip = dst_ip_r;
        meta_flit.dst_ip = src_ip_r;
        meta_flit.src_port = dst_port_r;
        meta_flit.dst_port = src_port_r;
        meta_flit.data_length = resp_len;
    end

    always_comb begin
        case (out_sel)
            hdr:     noc_out_data = hdr_flit;
            meta:    noc_out_data = meta_flit;
            default: noc_out_data = enc_out_data;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/udp_rs_encode_pkg.sv
`default_nettype none

package udp_rs_encode_pkg;

    localparam int ip_addr_w = 32;
    localparam int port_num_w = 16;
    localparam int udp_length_w = 16;

    typedef struct packed {
        logic [ip_addr_w-1:0]    src_ip;
        logic [ip_addr_w-1:0]    dst_ip;
        logic [port_num_w-1:0]   src_port;
        logic [port_num_w-1:0]   dst_port;
        logic [udp_length_w-1:0] data_length;
        logic [15:0]             padding;
    } udp_metadata_flit;

    // RS(255,239) over GF(2^8), x^8 + x^4 + x^3 + x^2 + 1
    localparam int rs_t = 16;
    localparam logic [7:0] rs_gf_poly = 8'h1d;

    localparam int client_num_blocks_w = 8;

    typedef enum logic [1:0] {hdr, meta, data} udp_rs_tx_flit_e;

endpackage

`default_nettype wire

// File: hdl/udp_rs_encode_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_top
    import udp_rs_noc_pkg::*;
    import udp_rs_encode_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      noc_in_val,
    input  logic [noc_data_width-1:0] noc_in_data,
    output logic                      noc_in_rdy,
    output logic                      noc_out_val,
    output logic [noc_data_width-1:0] noc_out_data,
    input  logic                      noc_out_rdy
);

    logic                           meta_val;
    logic [ip_addr_w-1:0]           src_ip;
    logic [ip_addr_w-1:0]           dst_ip;
    logic [port_num_w-1:0]          src_port;
    logic [port_num_w-1:0]          dst_port;
    logic [udp_length_w-1:0]        data_len;
    logic [client_num_blocks_w-1:0] num_blocks;

    logic                           enc_in_val;
    logic [noc_data_width-1:0]      enc_in_data;
    logic                           enc_in_rdy;
    logic                           enc_out_val;
    logic [noc_data_width-1:0]      enc_out_data;
    logic                           enc_out_rdy;

    logic                           store_meta;
    udp_rs_tx_flit_e                out_sel;
    logic                           incr_data_flit;
    logic                           last_data_flit;

    udp_rs_encode_in encode_in (
        .clk         (clk),
        .rst         (rst),
        .noc_in_val  (noc_in_val),
        .noc_in_data (noc_in_data),
        .noc_in_rdy  (noc_in_rdy),
        .enc_in_val  (enc_in_val),
        .enc_in_data (enc_in_data),
        .enc_in_rdy  (enc_in_rdy),
        .meta_val    (meta_val),
        // the handoff completes when the output side latches the record
        .meta_rdy    (store_meta),
        .src_ip      (src_ip),
        .dst_ip      (dst_ip),
        .src_port    (src_port),
        .dst_port    (dst_port),
        .data_len    (data_len),
        .num_blocks  (num_blocks)
    );

    udp_rs_stream_encoder stream_encoder (
        .clk          (clk),
        .rst          (rst),
        .enc_in_val   (enc_in_val),
        .enc_in_data  (enc_in_data),
        .enc_in_rdy   (enc_in_rdy),
        .enc_out_val  (enc_out_val),
        .enc_out_data (enc_out_data),
        .enc_out_rdy  (enc_out_rdy)
    );

    udp_rs_encode_out_ctrl out_ctrl (
        .clk            (clk),
        .rst            (rst),
        .meta_val       (meta_val),
        .enc_out_val    (enc_out_val),
        .noc_out_rdy    (noc_out_rdy),
        .last_data_flit (last_data_flit),
        .store_meta     (store_meta),
        .out_sel        (out_sel),
        .incr_data_flit (incr_data_flit),
        .noc_out_val    (noc_out_val),
        .enc_out_rdy    (enc_out_rdy)
    );

    udp_rs_encode_out_datap out_datap (
        .clk            (clk),
        .rst            (rst),
        .src_ip         (src_ip),
        .dst_ip         (dst_ip),
        .src_port       (src_port),
        .dst_port       (dst_port),
        .data_len       (data_len),
        .num_blocks     (num_blocks),
        .enc_out_data   (enc_out_data),
        .store_meta     (store_meta),
        .out_sel        (out_sel),
        .incr_data_flit (incr_data_flit),
        .noc_out_data   (noc_out_data),
        .last_data_flit (last_data_flit)
    );

endmodule

`default_nettype wire

// File: hdl/udp_rs_noc_pkg.sv
`default_nettype none

package udp_rs_noc_pkg;

    localparam int noc_data_width = 128;
    localparam int noc_data_bytes = 16;
    localparam int noc_data_bytes_w = 4;

    localparam int xy_width = 8;
    localparam int msg_length_width = 8;

    // first field sits in the top bits of the flit
    typedef struct packed {
        logic [xy_width-1:0]         dst_x;
        logic [xy_width-1:0]         dst_y;
        logic [xy_width-1:0]         src_x;
        logic [xy_width-1:0]         src_y;
        logic [msg_length_width-1:0] msg_len;
        logic [7:0]                  msg_type;
        logic [7:0]                  metadata_flits;
        logic [noc_data_width-56-1:0] padding;
    } noc_hdr_flit;

    localparam logic [7:0] udp_rx_segment = 8'd6;
    localparam logic [7:0] udp_tx_segment = 8'd7;

    // position of this tile on the mesh
    localparam logic [xy_width-1:0] encode_tile_x = 8'd2;
    localparam logic [xy_width-1:0] encode_tile_y = 8'd1;

    // responses always go out through the UDP TX tile
    localparam logic [xy_width-1:0] udp_tx_tile_x = 8'd1;
    localparam logic [xy_width-1:0] udp_tx_tile_y = 8'd0;

endpackage

`default_nettype wire

// File: hdl/udp_rs_stream_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rs_stream_encoder
    import udp_rs_noc_pkg::*;
    import udp_rs_encode_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enc_in_val,
    input  logic [noc_data_width-1:0] enc_in_data,
    output logic                      enc_in_rdy,
    output logic                      enc_out_val,
    output logic [noc_data_width-1:0] enc_out_data,
    input  logic                      enc_out_rdy
);

    logic [8*rs_t-1:0] parity_comb;
    logic [8*rs_t-1:0] parity_reg;
    logic              parity_pend;

    rs_block_parity parity_calc (
        .block  (enc_in_data),
        .parity (parity_comb)
    );

    // data goes straight through, parity follows on the next transfer
    assign enc_in_rdy = ~parity_pend & enc_out_rdy;
    assign enc_out_val = parity_pend | enc_in_val;
    assign enc_out_data = parity_pend ? parity_reg : enc_in_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            parity_pend <= 1'b0;
        end else if (enc_in_val && enc_in_rdy) begin
            parity_pend <= 1'b1;
        end else if (parity_pend && enc_out_rdy) begin
            parity_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (enc_in_val && enc_in_rdy) begin
            parity_reg <= parity_comb;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the encode tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module udp_rs_encode_tb -Mdir obj_dir -o udp_rs_encode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/udp_rs_encode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sources.f
+incdir+tests
hdl/udp_rs_noc_pkg.sv
hdl/udp_rs_encode_pkg.sv
hdl/rs_block_parity.sv
hdl/udp_rs_stream_encoder.sv
hdl/udp_rs_encode_in.sv
hdl/udp_rs_encode_out_ctrl.sv
hdl/udp_rs_encode_out_datap.sv
hdl/udp_rs_encode_top.sv
tests/udp_rs_encode_tb.sv

// File: tests/udp_rs_encode_ref.svh
`ifndef UDP_RS_ENCODE_REF_SVH
`define UDP_RS_ENCODE_REF_SVH

// GF(2^8) multiply, field polynomial 0x11d, high bit of b first
function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 7; i >= 0; i--) begin
        p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1d : 8'h00);
        if (b[i]) begin
            p = p ^ a;
        end
    end
    return p;
endfunction

// generator coefficients, byte j holds the coefficient of x^(16-j)
function automatic logic [135:0] generator_desc();
    logic [7:0]   q [17];
    logic [7:0]   r;
    logic [135:0] g;
    for (int j = 0; j < 17; j++) begin
        q[j] = 8'h00;
    end
    q[0] = 8'h01;
    r = 8'h01;
    for (int i = 0; i < 16; i++) begin
        // multiply by (x + alpha^i)
        for (int j = i + 1; j > 0; j--) begin
            q[j] = q[j] ^ gf_mult(q[j-1], r);
        end
        r = gf_mult(r, 8'h02);
    end
    for (int j = 0; j < 17; j++) begin
        g[8*j +: 8] = q[j];
    end
    return g;
endfunction

// long division of m(x) * x^16 by g(x), block byte 0 is the top coefficient
function automatic logic [127:0] rs_parity(input logic [127:0] blk);
    logic [7:0]   cw [32];
    logic [135:0] g;
    logic [7:0]   c;
    logic [127:0] par;
    g = generator_desc();
    for (int i = 0; i < 32; i++) begin
        cw[i] = (i < 16) ? blk[8*i +: 8] : 8'h00;
    end
    for (int i = 0; i < 16; i++) begin
        c = cw[i];
        for (int j = 0; j < 17; j++) begin
            cw[i+j] = cw[i+j] ^ gf_mult(g[8*j +: 8], c);
        end
    end
    for (int k = 0; k < 16; k++) begin
        par[8*k +: 8] = cw[16+k];
    end
    return par;
endfunction

function automatic logic [127:0] expected_hdr(input int nb);
    noc_hdr_flit h;
    h = '0;
    h.dst_x = udp_tx_tile_x;
    h.dst_y = udp_tx_tile_y;
    h.src_x = encode_tile_x;
    h.src_y = encode_tile_y;
    h.msg_len = 8'(1 + 2 * nb);
    h.msg_type = udp_tx_segment;
    h.metadata_flits = 8'd1;
    return h;
endfunction

function automatic logic [127:0] expected_meta(input logic [31:0] sip, input logic [31:0] dip,
                                               input logic [15:0] sp, input logic [15:0] dp,
                                               input int data_len, input int nb);
    udp_metadata_flit m;
    m = '0;
    m.src_ip = dip;
    m.dst_ip = sip;
    m.src_port = dp;
    m.dst_port = sp;
    // client flit dropped, parity added
    m.data_length = 16'(data_len + 16 * nb - 16);
    return m;
endfunction

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`endif

// File: tests/udp_rs_encode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rs_encode_tb
    import udp_rs_noc_pkg::*;
    import udp_rs_encode_pkg::*;
;

    `include "udp_rs_encode_ref.svh"

    localparam int num_requests = 26;
    localparam int max_blocks = 10 + 5 + 20 * 4;
    localparam int timeout_cycles = 40 * max_blocks + 100 * num_requests;

    logic         clk;
    logic         rst;
    logic         noc_in_val;
    logic [127:0] noc_in_data;
    logic         noc_in_rdy;
    logic         noc_out_val;
    logic [127:0] noc_out_data;
    logic         noc_out_rdy;

    logic [31:0]  lfsr_state = 32'he95b_9fbb;
    logic [127:0] exp_q [$];
    logic         rdy_random = 1'b0;
    logic         rdy_draw = 1'b1;
    int           errors = 0;
    int           checked = 0;
    int           cycle_cnt = 0;

    udp_rs_encode_top uut (
        .clk          (clk),
        .rst          (rst),
        .noc_in_val   (noc_in_val),
        .noc_in_data  (noc_in_data),
        .noc_in_rdy   (noc_in_rdy),
        .noc_out_val  (noc_out_val),
        .noc_out_data (noc_out_data),
        .noc_out_rdy  (noc_out_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_flit(input logic [127:0] flit);
        logic taken;
        noc_in_val = 1'b1;
        noc_in_data = flit;
        taken = 1'b0;
        while (!taken) begin
            #1;
            taken = noc_in_rdy;
            @(negedge clk);
        end
    endtask

    // fill selects random blocks (0), all zeros (1) or all ones (2)
    task automatic send_request(input int nb, input int fill);
        noc_hdr_flit  h;
        udp_metadata_flit m;
        logic [127:0] blk;
        int           data_len;
        data_len = 16 * (nb + 1);
        h = '0;
        h.dst_x = encode_tile_x;
        h.dst_y = encode_tile_y;
        h.msg_len = 8'(2 + nb);
        h.msg_type = udp_rx_segment;
        h.metadata_flits = 8'd1;
        m = '0;
        m.src_ip = rand_bits(32);
        m.dst_ip = rand_bits(32);
        m.src_port = 16'(rand_bits(16));
        m.dst_port = 16'(rand_bits(16));
        m.data_length = 16'(data_len);
        exp_q.push_back(expected_hdr(nb));
        exp_q.push_back(expected_meta(m.src_ip, m.dst_ip, m.src_port, m.dst_port, data_len, nb));
        send_flit(h);
        send_flit(m);
        send_flit(128'(nb));
        for (int b = 0; b < nb; b++) begin
            if (fill == 1) begin
                blk = '0;
            end else if (fill == 2) begin
                blk = '1;
            end else begin
                for (int w = 0; w < 4; w++) begin
                    blk[32*w +: 32] = rand_bits(32);
                end
            end
            exp_q.push_back(blk);
            exp_q.push_back(rs_parity(blk));
            send_flit(blk);
        end
        noc_in_val = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
    endtask

    // next ready value is drawn on the rising edge
    always @(posedge clk) begin
        if (rdy_random) begin
            rdy_draw = rand_bits(2) != 2'd0;
        end
    end

    always @(negedge clk) begin
        if (rdy_random) begin
            noc_out_rdy = rdy_draw;
        end
    end

    // compare process samples between the falling and the rising edge
    always @(negedge clk) begin
        logic [127:0] exp;
        #2;
        if (!rst && noc_out_val && noc_out_rdy) begin
            if (exp_q.size() == 0) begin
                $display("[ERROR] %0t: unexpected output flit %h", $time, noc_out_data);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                if (noc_out_data != exp) begin
                    $display("[ERROR] %0t: flit %0d expected %h got %h",
                             $time, checked, exp, noc_out_data);
                    errors++;
                end
                checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timed out after %0d cycles with %0d flits outstanding",
                     cycle_cnt, exp_q.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        noc_in_val = 1'b0;
        noc_in_data = '0;
        noc_out_rdy = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        // output must stay quiet with no request pending
        repeat (10) begin
            @(negedge clk);
            #2;
            if (noc_out_val) begin
                $display("[ERROR] %0t: noc_out_val high before any request", $time);
                errors++;
            end
            if (!noc_in_rdy) begin
                $display("[ERROR] %0t: noc_in_rdy low while idle after reset", $time);
                errors++;
            end
        end
        @(negedge clk);
        send_request(1, 1);
        wait_drain();
        send_request(2, 2);
        wait_drain();
        send_request(3, 0);
        wait_drain();
        send_request(4, 0);
        wait_drain();
        // back to back requests with the next header right after the last block
        send_request(3, 0);
        send_request(2, 0);
        wait_drain();
        rdy_random = 1'b1;
        for (int r = 0; r < 20; r++) begin
            send_request(1 + int'(rand_bits(2)), 0);
        end
        wait_drain();
        rdy_random = 1'b0;
        noc_out_rdy = 1'b1;
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("response incomplete, %0d expected flits never arrived", exp_q.size());
            errors++;
        end
        $display("errors: %0d, flits checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
